// File: rtl/uart_frame_pkg.sv
`default_nettype none

package uart_frame_pkg;

    localparam int data_bits     = 8;                      // Data bits per frame
    localparam int bit_idx_width = $clog2(data_bits);      // Data bit counter width
    localparam int divisor_width = 16;                     // Bit-period counter width

    localparam logic [divisor_width-1:0] divisor_reset = 16; // Bit period after reset

    localparam logic line_idle      = 1'b1;                // Idle level, also the stop bit
    localparam logic line_start_bit = 1'b0;

    typedef enum logic [2:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_parity,
        tx_st_stop
    } tx_state_e;

    typedef enum logic [2:0] {
        rx_st_idle,
        rx_st_start,                                       // Waiting for mid start bit
        rx_st_data,
        rx_st_parity,
        rx_st_stop
    } rx_state_e;

endpackage

`default_nettype wire

// File: rtl/uart_bus_pkg.sv
`default_nettype none

package uart_bus_pkg;

    localparam int wb_data_width = 32;
    localparam int wb_addr_width = 2;                      // Word address

    localparam logic [wb_addr_width-1:0] addr_data   = 2'd0;
    localparam logic [wb_addr_width-1:0] addr_status = 2'd1;
    localparam logic [wb_addr_width-1:0] addr_ctrl   = 2'd2;

    // STATUS bit positions
    localparam int stat_tx_busy    = 0;
    localparam int stat_rx_valid   = 1;
    localparam int stat_parity_err = 2;                    // Sticky, write one to clear
    localparam int stat_frame_err  = 3;                    // Sticky, write one to clear
    localparam int stat_overrun    = 4;                    // Sticky, write one to clear

    // DATA view of a bus word
    typedef struct packed {
        logic [wb_data_width-uart_frame_pkg::data_bits-1:0] unused;
        logic [uart_frame_pkg::data_bits-1:0]               char;
    } wb_char_t;

    // CTRL view of a bus word
    typedef struct packed {
        logic [wb_data_width-uart_frame_pkg::divisor_width-2:0] unused;
        logic                                                   parity_en;
        logic [uart_frame_pkg::divisor_width-1:0]               divisor;
    } wb_ctrl_t;

    typedef union packed {
        wb_char_t chr;
        wb_ctrl_t ctrl;
    } wb_word_u;

endpackage

`default_nettype wire

// File: rtl/uart_char_if.sv
`timescale 1ns/1ns
`default_nettype none

interface uart_char_if;
    import uart_frame_pkg::*;

    logic                     tx_start;                    // One-cycle send request
    logic [data_bits-1:0]     tx_char;
    logic                     tx_busy;

    logic                     rx_valid;                    // One-cycle, frame complete
    logic [data_bits-1:0]     rx_char;
    logic                     rx_parity_err;
    logic                     rx_frame_err;

    logic [divisor_width-1:0] divisor;                     // Bit period in clocks
    logic                     parity_en;

    modport regs (
        output tx_start, tx_char, divisor, parity_en,
        input  tx_busy, rx_valid, rx_char, rx_parity_err, rx_frame_err
    );

    modport tx (
        input  tx_start, tx_char, divisor, parity_en,
        output tx_busy
    );

    modport rx (
        input  divisor, parity_en,
        output rx_valid, rx_char, rx_parity_err, rx_frame_err
    );
endinterface

`default_nettype wire

// File: rtl/uart_wb_regs.sv
`timescale 1ns/1ns
`default_nettype none

module uart_wb_regs (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [uart_bus_pkg::wb_addr_width-1:0] wb_adr,
    input  logic [uart_bus_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [uart_bus_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                                   wb_ack,
    uart_char_if.regs                              ch
);
    import uart_bus_pkg::*;
    import uart_frame_pkg::*;

    wb_word_u                 wr_word;
    wb_word_u                 ctrl_word;                   // CTRL readback
    logic [wb_data_width-1:0] status_word;
    logic                     req;
    logic                     data_wr;
    logic                     accept;
    logic                     rd_clr;
    logic                     sts_wr;
    logic [data_bits-1:0]     rx_hold;
    logic                     rx_full;
    logic                     parity_err;
    logic                     frame_err;
    logic                     overrun;

    assign wr_word = wb_dat_w;
    assign req     = wb_cyc && wb_stb && !wb_ack;          // No new request in the ack cycle
    assign data_wr = wb_we && (wb_adr == addr_data);
    assign accept  = req && !(data_wr && ch.tx_busy);      // DATA write waits for tx idle
    assign rd_clr  = accept && !wb_we && (wb_adr == addr_data);
    assign sts_wr  = accept && wb_we && (wb_adr == addr_status);

    always_comb begin
        status_word                  = '0;
        status_word[stat_tx_busy]    = ch.tx_busy;
        status_word[stat_rx_valid]   = rx_full;
        status_word[stat_parity_err] = parity_err;
        status_word[stat_frame_err]  = frame_err;
        status_word[stat_overrun]    = overrun;
        ctrl_word                    = '0;
        ctrl_word.ctrl.divisor       = ch.divisor;
        ctrl_word.ctrl.parity_en     = ch.parity_en;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack       <= 1'b0;
            ch.tx_start  <= 1'b0;
            ch.divisor   <= divisor_reset;
            ch.parity_en <= 1'b0;
        end else begin
            wb_ack      <= accept;
            ch.tx_start <= accept && data_wr;              // Lands in the ack cycle
            if (accept && wb_we && (wb_adr == addr_ctrl)) begin
                ch.divisor   <= wr_word.ctrl.divisor;
                ch.parity_en <= wr_word.ctrl.parity_en;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept && data_wr) begin
            ch.tx_char <= wr_word.chr.char;
        end
        if (accept && !wb_we) begin
            case (wb_adr)
                addr_data:   wb_dat_r <= wb_data_width'(rx_hold);
                addr_status: wb_dat_r <= status_word;
                addr_ctrl:   wb_dat_r <= ctrl_word;
                default:     wb_dat_r <= '0;
            endcase
        end
    end

    // Receive holding register and sticky flags
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_full    <= 1'b0;
            parity_err <= 1'b0;
            frame_err  <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            rx_full    <= ch.rx_valid || (rx_full && !rd_clr);
            parity_err <= (parity_err && !(sts_wr && wb_dat_w[stat_parity_err]))
                          || (ch.rx_valid && ch.rx_parity_err);
            frame_err  <= (frame_err && !(sts_wr && wb_dat_w[stat_frame_err]))
                          || (ch.rx_valid && ch.rx_frame_err);
            overrun    <= (overrun && !(sts_wr && wb_dat_w[stat_overrun]))
                          || (ch.rx_valid && rx_full && !rd_clr);
        end
    end

    always_ff @(posedge clk) begin
        if (ch.rx_valid && !(rx_full && !rd_clr)) begin
            rx_hold <= ch.rx_char;                         // Old char kept on overrun
        end
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
        else $error("wb_ack rose without an active request");

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        ch.tx_start |-> !ch.tx_busy)
        else $error("tx_start issued while the transmitter is busy");

endmodule

`default_nettype wire

// File: rtl/uart_tx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_tx (
    input  logic   clk,
    input  logic   rst,
    uart_char_if.tx ch,
    output logic   line_out
);
    import uart_frame_pkg::*;

    tx_state_e                state;
    logic [divisor_width-1:0] cnt;
    logic [divisor_width-1:0] period;                      // Divisor latched per frame
    logic [data_bits-1:0]     shift;
    logic [bit_idx_width-1:0] bit_idx;
    logic                     parity_bit;
    logic                     parity_on;
    logic                     period_done;

    assign period_done = (cnt == period - 1'b1);

    // Frame payload, loaded at the request
    always_ff @(posedge clk) begin
        if (state == tx_st_idle && ch.tx_start) begin
            shift      <= ch.tx_char;
            parity_bit <= ^ch.tx_char;                     // Even parity
            period     <= ch.divisor;
            parity_on  <= ch.parity_en;
        end else if (period_done && (state == tx_st_start || state == tx_st_data)) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= tx_st_idle;
            line_out   <= line_idle;
            ch.tx_busy <= 1'b0;
            cnt        <= '0;
            bit_idx    <= '0;
        end else begin
            if (state != tx_st_idle) begin
                cnt <= period_done ? '0 : cnt + 1'b1;
            end
            case (state)
                tx_st_idle: begin
                    if (ch.tx_start) begin
                        state      <= tx_st_start;
                        line_out   <= line_start_bit;      // Start bit goes out at once
                        ch.tx_busy <= 1'b1;
                    end
                end
                tx_st_start: begin
                    if (period_done) begin
                        state    <= tx_st_data;
                        line_out <= shift[0];
                        bit_idx  <= '0;
                    end
                end
                tx_st_data: begin
                    if (period_done) begin
                        if (bit_idx == bit_idx_width'(data_bits - 1)) begin
                            state    <= parity_on ? tx_st_parity : tx_st_stop;
                            line_out <= parity_on ? parity_bit : line_idle;
                        end else begin
                            bit_idx  <= bit_idx + 1'b1;
                            line_out <= shift[0];          // LSB first
                        end
                    end
                end
                tx_st_parity: begin
                    if (period_done) begin
                        state    <= tx_st_stop;
                        line_out <= line_idle;
                    end
                end
                tx_st_stop: begin
                    if (period_done) begin
                        state      <= tx_st_idle;
                        ch.tx_busy <= 1'b0;                // End of the stop bit
                    end
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

    idle_line_high: assert property (@(posedge clk) disable iff (rst)
        (state == tx_st_idle) |-> (line_out == line_idle))
        else $error("tx line not idle in the idle state");

endmodule

`default_nettype wire

// File: rtl/uart_rx.sv
`timescale 1ns/1ns
`default_nettype none

module uart_rx (
    input  logic   clk,
    input  logic   rst,
    uart_char_if.rx ch,
    input  logic   line_in
);
    import uart_frame_pkg::*;

    rx_state_e                state;
    logic [2:0]               sync;                        // Two sync flops and edge history
    logic                     line_s;
    logic                     fall;
    logic [divisor_width-1:0] cnt;
    logic [divisor_width-1:0] bit_end;
    logic [divisor_width-1:0] half_end;
    logic [bit_idx_width-1:0] bit_idx;
    logic                     sample;

    assign line_s   = sync[1];
    assign fall     = sync[2] && !sync[1];
    assign bit_end  = ch.divisor - 1'b1;
    assign half_end = (ch.divisor >> 1) - 1'b1;            // Mid start bit
    assign sample   = (cnt == bit_end);

    // Data bits shift in from the top, LSB arrives first
    always_ff @(posedge clk) begin
        if (state == rx_st_data && sample) begin
            ch.rx_char <= {line_s, ch.rx_char[data_bits-1:1]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sync             <= {3{line_idle}};
            state            <= rx_st_idle;
            cnt              <= '0;
            bit_idx          <= '0;
            ch.rx_valid      <= 1'b0;
            ch.rx_parity_err <= 1'b0;
            ch.rx_frame_err  <= 1'b0;
        end else begin
            sync        <= {sync[1:0], line_in};
            ch.rx_valid <= 1'b0;
            case (state)
                rx_st_idle: begin
                    cnt <= '0;
                    if (fall) begin
                        state <= rx_st_start;
                    end
                end
                rx_st_start: begin
                    if (cnt == half_end) begin
                        cnt <= '0;
                        if (line_s == line_start_bit) begin
                            state            <= rx_st_data;
                            bit_idx          <= '0;
                            ch.rx_parity_err <= 1'b0;
                            ch.rx_frame_err  <= 1'b0;
                        end else begin
                            state <= rx_st_idle;   // Glitch, not a start bit
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                rx_st_data: begin
                    cnt <= sample ? '0 : cnt + 1'b1;
                    if (sample) begin
                        if (bit_idx == bit_idx_width'(data_bits - 1)) begin
                            state <= ch.parity_en ? rx_st_parity : rx_st_stop;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                rx_st_parity: begin
                    cnt <= sample ? '0 : cnt + 1'b1;
                    if (sample) begin
                        ch.rx_parity_err <= line_s != ^ch.rx_char; // Even parity check
                        state            <= rx_st_stop;
                    end
                end
                rx_st_stop: begin
                    if (ch.rx_valid) begin
                        state <= rx_st_idle;               // Pulse done, back to idle
                    end else if (sample) begin
                        cnt             <= '0;
                        ch.rx_valid     <= 1'b1;
                        ch.rx_frame_err <= line_s != line_idle;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= rx_st_idle;
            endcase
        end
    end

    no_valid_in_idle: assert property (@(posedge clk) disable iff (rst)
        ch.rx_valid |-> (state != rx_st_idle))
        else $error("rx_valid pulsed in the idle state");

endmodule

`default_nettype wire

// File: rtl/uart_top.sv
`timescale 1ns/1ns
`default_nettype none

module uart_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   wb_cyc,
    input  logic                                   wb_stb,
    input  logic                                   wb_we,
    input  logic [uart_bus_pkg::wb_addr_width-1:0] wb_adr,
    input  logic [uart_bus_pkg::wb_data_width-1:0] wb_dat_w,
    output logic [uart_bus_pkg::wb_data_width-1:0] wb_dat_r,
    output logic                                   wb_ack,
    output logic                                   uart_txd,
    input  logic                                   uart_rxd
);

    uart_char_if char_bus ();                              // Register block to engines

    uart_wb_regs i_regs (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ch       (char_bus.regs)
    );

    uart_tx i_tx (
        .clk      (clk),
        .rst      (rst),
        .ch       (char_bus.tx),
        .line_out (uart_txd)
    );

    uart_rx i_rx (
        .clk      (clk),
        .rst      (rst),
        .ch       (char_bus.rx),
        .line_in  (uart_rxd)                               // Asynchronous serial input
    );

endmodule

`default_nettype wire

// File: verification/tb_uart_tests.svh
`ifndef TB_UART_TESTS_SVH
`define TB_UART_TESTS_SVH
`default_nettype none

    logic       m_valid;                                   // Receive side of the model
    logic [7:0] m_hold;
    logic       m_perr;
    logic       m_ferr;
    logic       m_ovr;

    function automatic logic even_parity(input logic [7:0] c);
        logic p;
        p = 1'b0;
        for (int i = 0; i < 8; i++) begin
            p = p ^ c[i];
        end
        return p;
    endfunction

    function automatic logic [31:0] model_status();
        logic [31:0] s;
        s                  = '0;
        s[stat_rx_valid]   = m_valid;
        s[stat_parity_err] = m_perr;
        s[stat_frame_err]  = m_ferr;
        s[stat_overrun]    = m_ovr;
        return s;
    endfunction

    task automatic model_receive(input logic [7:0] c, input logic perr, input logic ferr);
        if (m_valid) begin
            m_ovr = 1'b1;                                  // First character stays
        end else begin
            m_hold = c;
        end
        m_valid = 1'b1;
        m_perr  = m_perr | perr;
        m_ferr  = m_ferr | ferr;
    endtask

    task automatic set_ctrl(input logic [15:0] div, input logic par);
        wb_word_u w;
        w                = '0;
        w.ctrl.divisor   = div;
        w.ctrl.parity_en = par;
        wb_write(addr_ctrl, w);
    endtask

    task automatic send_char(input logic [7:0] c);
        wb_word_u w;
        w          = '0;
        w.chr.char = c;
        wb_write(addr_data, w);
    endtask

    task automatic wait_for_status(input string name, input int bit_pos);
        logic [31:0] rd;
        int          tries;
        tries = 0;
        do begin
            wb_read(addr_status, rd);
            tries++;
        end while (!rd[bit_pos] && tries < 250);
        if (!rd[bit_pos]) begin
            errors++;
            $display("%s: STATUS bit %0d was never set", name, bit_pos);
        end
    endtask

    // tx_busy is left out of the compare, the stop bit may still be on the line
    task automatic check_status(input string name);
        logic [31:0] rd;
        wb_read(addr_status, rd);
        check_value(name, model_status(), rd & ~(32'd1 << stat_tx_busy));
    endtask

    task automatic receive_expect(input string name, input logic [7:0] c,
                                  input logic perr, input logic ferr);
        logic [31:0] rd;
        model_receive(c, perr, ferr);
        wait_for_status(name, stat_rx_valid);
        check_status({name, " status"});
        wb_read(addr_data, rd);
        check_value({name, " data"}, 32'(m_hold), rd);
        m_valid = 1'b0;
    endtask

    // Start, 8 data bits LSB first, parity, stop
    task automatic drive_frame(input logic [7:0] c, input logic pbit, input logic stop,
                               input int div);
        logic [10:0] bits;
        bits = {stop, pbit, c, 1'b0};
        for (int i = 0; i < 11; i++) begin
            drv_line = bits[i];
            repeat (div) @(negedge clk);
        end
        drv_line = 1'b1;
    endtask

    task automatic test_reset();
        logic [31:0] rd;
        m_valid = 1'b0;
        m_hold  = '0;
        m_perr  = 1'b0;
        m_ferr  = 1'b0;
        m_ovr   = 1'b0;
        wb_read(addr_status, rd);
        check_value("reset status", 32'd0, rd);
        wb_read(addr_ctrl, rd);
        check_value("reset ctrl", 32'd16, rd);             // Divisor 16, parity off
        check_value("reset txd", 32'd1, 32'(uart_txd));
    endtask

    task automatic test_loopback();
        logic [15:0] v;
        logic [15:0] par;
        logic [15:0] div;
        for (int i = 0; i < 20; i++) begin
            random_bits(5, v);
            div = 16'(4 + v % 17);                         // 4 to 20
            random_bits(1, par);
            random_bits(8, v);
            set_ctrl(div, par[0]);
            send_char(v[7:0]);
            receive_expect($sformatf("loopback %0d", i), v[7:0], 1'b0, 1'b0);
        end
    endtask

    task automatic test_backpressure();
        logic [31:0] rd;
        int          waited;
        set_ctrl(16'd8, 1'b0);
        send_char(8'hA5);
        bus_cycle(1'b1, addr_data, 32'h3C, rd, waited);
        // Ack one cycle after busy falls, 10 bit periods after the start
        check_value("backpressure wait", 32'(10 * 8 + 2), 32'(waited));
        receive_expect("backpressure first", 8'hA5, 1'b0, 1'b0);
        receive_expect("backpressure second", 8'h3C, 1'b0, 1'b0);
    endtask

    task automatic test_bit_period();
        time t_fall;
        time t_rise;
        set_ctrl(16'd12, 1'b0);
        send_char(8'h55);                                  // LSB one ends the start bit
        @(negedge uart_txd);
        t_fall = $time;
        @(posedge uart_txd);
        t_rise = $time;
        @(negedge clk);
        check_value("start bit time", 32'(12 * clk_period), 32'(t_rise - t_fall));
        receive_expect("bit period frame", 8'h55, 1'b0, 1'b0);
    endtask

    task automatic test_error_frames();
        logic pbit;
        set_ctrl(16'd16, 1'b1);
        loop_en = 1'b0;
        pbit    = !even_parity(8'h96);
        drive_frame(8'h96, pbit, 1'b1, 16);
        receive_expect("parity frame", 8'h96, pbit != even_parity(8'h96), 1'b0);
        pbit = even_parity(8'h3B);
        drive_frame(8'h3B, pbit, 1'b0, 16);
        receive_expect("stop frame", 8'h3B, 1'b0, 1'b1);
        wb_write(addr_status, (32'd1 << stat_parity_err) | (32'd1 << stat_frame_err));
        m_perr = 1'b0;
        m_ferr = 1'b0;
        check_status("error flags cleared");
        loop_en = 1'b1;
    endtask

    task automatic test_overrun();
        logic [31:0] rd;
        set_ctrl(16'd6, 1'b0);
        send_char(8'h11);
        send_char(8'h22);
        model_receive(8'h11, 1'b0, 1'b0);
        model_receive(8'h22, 1'b0, 1'b0);
        wait_for_status("overrun", stat_overrun);
        check_status("overrun status");
        wb_read(addr_data, rd);
        check_value("overrun data", 32'(m_hold), rd);
        m_valid = 1'b0;
        wb_write(addr_status, 32'd1 << stat_overrun);
        m_ovr = 1'b0;
        check_status("overrun cleared");
    endtask

`default_nettype wire
`endif

// File: verification/tb_uart.sv
`timescale 1ns/1ns
`default_nettype none

module tb_uart;
    import uart_bus_pkg::*;
    import uart_frame_pkg::*;

    localparam int clk_period = 100;
    localparam int num_frames = 30;                        // 27 frames sent, rounded up
    localparam int max_div    = 20;
    localparam int timeout_ns = num_frames * 11 * max_div * clk_period * 2;

    logic                     clk;
    logic                     rst;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [wb_addr_width-1:0] wb_adr;
    logic [wb_data_width-1:0] wb_dat_w;
    logic [wb_data_width-1:0] wb_dat_r;
    logic                     wb_ack;
    logic                     uart_txd;
    logic                     uart_rxd;
    logic                     loop_en;                     // Loopback of txd into rxd
    logic                     drv_line;                    // Hand-built frames
    logic [15:0]              lfsr;
    int                       errors;
    int                       checks;

    assign uart_rxd = loop_en ? uart_txd : drv_line;

    uart_top i_dut (
        .clk      (clk),
        .rst      (rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .uart_txd (uart_txd),
        .uart_rxd (uart_rxd)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16 14 13 11
    endfunction

    task automatic random_bits(input int n, output logic [15:0] v);
        v = '0;
        repeat (n) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[14:0], lfsr[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("MISMATCH %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Starts and ends on a falling edge
    task automatic bus_cycle(input logic we, input logic [wb_addr_width-1:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int waited);
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [wb_addr_width-1:0] adr, input logic [31:0] data);
        logic [31:0] rd;
        int          waited;
        bus_cycle(1'b1, adr, data, rd, waited);
    endtask

    task automatic wb_read(input logic [wb_addr_width-1:0] adr, output logic [31:0] data);
        int waited;
        bus_cycle(1'b0, adr, '0, data, waited);
    endtask

    initial begin
        clk      = 1'b0;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        loop_en  = 1'b1;
        drv_line = 1'b1;
        lfsr     = 16'd74;
        errors   = 0;
        checks   = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        test_reset();
        test_loopback();
        test_backpressure();
        test_bit_period();
        test_error_frames();
        test_overrun();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: tests still running after %0d ns", timeout_ns);
        $display("Errors found");
        $finish;
    end

    `include "tb_uart_tests.svh"
endmodule

`default_nettype wire

// File: all.f
+incdir+verification
rtl/uart_frame_pkg.sv
rtl/uart_bus_pkg.sv
rtl/uart_char_if.sv
rtl/uart_wb_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
verification/tb_uart.sv

// File: run.sh
#!/bin/sh
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_uart -f all.f -o tb_uart_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_uart_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" sim.log; then
    exit 0
fi
echo "Simulation reported failures"
exit 1
